//--- src/fir_reg_pkg.sv
`default_nettype none

package fir_reg_pkg;

    // byte address and data word on the register port
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    ////////////////////////////////////////
    // register map

    localparam reg_addr_t addr_ap_ctrl     = 12'h000;
    localparam reg_addr_t addr_data_length = 12'h010;
    localparam reg_addr_t addr_tap_count   = 12'h014;
    // coefficient k sits at base + 4*k
    localparam reg_addr_t addr_coef_base   = 12'h080;

    ////////////////////////////////////////
    // ap_ctrl fields

    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

endpackage

`default_nettype wire

//--- src/fir_data_pkg.sv
`default_nettype none

package fir_data_pkg;

    // datapath words truncated to 32 bits
    typedef logic [31:0] sample_t;
    typedef logic [31:0] coef_t;
    typedef logic [31:0] acc_t;

    // addresses both the coefficient store and the ring
    typedef logic [4:0] tap_idx_t;

    ////////////////////////////////////////
    // engine sequencing

    typedef enum logic [2:0] {
        st_clear,
        st_idle,
        st_wait_sample,
        st_compute,
        st_hold_result,
        st_done
    } engine_state_t;

endpackage

`default_nettype wire

//--- src/fir_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module fir_ctrl_regs
    import fir_reg_pkg::*;
    import fir_data_pkg::*;
#(
    parameter int max_taps = 32
) (
    input  wire logic                       axis_clk,
    input  wire logic                       axis_rst_n,
    input  wire logic                       awvalid,
    input  wire reg_addr_t                  awaddr,
    input  wire logic                       wvalid,
    input  wire reg_data_t                  wdata,
    output logic                            awready,
    output logic                            wready,
    input  wire logic                       arvalid,
    input  wire reg_addr_t                  araddr,
    input  wire logic                       rready,
    output logic                            arready,
    output logic                            rvalid,
    output reg_data_t                       rdata,
    input  wire tap_idx_t                   coef_idx,
    output coef_t                           coef,
    output logic                            start,
    output logic [$bits(tap_idx_t):0]       tap_count,
    output reg_data_t                       data_length,
    input  wire logic                       run_done,
    output logic                            run_idle
);

    localparam reg_addr_t coef_end = addr_coef_base + reg_addr_t'(4 * max_taps);

    logic      ap_done;
    logic      ap_idle;
    logic      wr_fire;
    logic      rd_fire;
    logic      coef_wr_hit;
    logic      coef_rd_hit;
    reg_data_t ap_ctrl_word;
    coef_t     coef_mem [max_taps];

    assign wr_fire     = awvalid && wvalid && awready && wready;
    assign rd_fire     = arvalid && arready;
    assign coef_wr_hit = (awaddr >= addr_coef_base) && (awaddr < coef_end);
    assign coef_rd_hit = (araddr >= addr_coef_base) && (araddr < coef_end);
    assign run_idle    = ap_idle;
    assign coef        = coef_mem[coef_idx];

    always_comb begin
        ap_ctrl_word               = '0;
        ap_ctrl_word[ap_start_bit] = start;
        ap_ctrl_word[ap_done_bit]  = ap_done;
        ap_ctrl_word[ap_idle_bit]  = ap_idle;
    end

    ////////////////////////////////////////
    // handshakes

    // write takes both channels in one beat
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready;
            wready  <= awvalid && wvalid && !awready;
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data is held until rready
    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            if (araddr == addr_ap_ctrl) begin
                rdata <= ap_ctrl_word;
            end else if (araddr == addr_data_length) begin
                rdata <= data_length;
            end else if (araddr == addr_tap_count) begin
                rdata <= reg_data_t'(tap_count);
            end else if (coef_rd_hit) begin
                rdata <= coef_mem[araddr[2 +: $bits(tap_idx_t)]];
            end else begin
                rdata <= '0;
            end
        end
    end

    ////////////////////////////////////////
    // ap_ctrl and configuration

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start       <= 1'b0;
            ap_done     <= 1'b0;
            ap_idle     <= 1'b1;
            data_length <= '0;
            tap_count   <= ($bits(tap_idx_t) + 1)'(max_taps);
        end else begin
            start <= wr_fire && (awaddr == addr_ap_ctrl) && wdata[ap_start_bit] && ap_idle;
            // start shows for one cycle together with idle
            if (start) begin
                ap_idle <= 1'b0;
            end
            if (run_done) begin
                ap_done <= 1'b1;
            end
            // status read ends the run
            if (rd_fire && (araddr == addr_ap_ctrl) && ap_done) begin
                ap_done <= 1'b0;
                ap_idle <= 1'b1;
            end
            if (wr_fire && ap_idle) begin
                if (awaddr == addr_data_length) begin
                    data_length <= wdata;
                end
                if (awaddr == addr_tap_count) begin
                    tap_count <= wdata[$bits(tap_idx_t):0];
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_fire && ap_idle && coef_wr_hit) begin
            coef_mem[awaddr[2 +: $bits(tap_idx_t)]] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/fir_sample_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fir_sample_buffer
    import fir_data_pkg::*;
#(
    parameter int max_taps = 32
) (
    input  wire logic     axis_clk,
    input  wire logic     axis_rst_n,
    input  wire logic     start,
    input  wire logic     run_idle,
    input  wire logic     ss_tvalid,
    input  wire sample_t  ss_tdata,
    output logic          ss_tready,
    input  wire tap_idx_t rd_idx,
    output sample_t       rd_sample,
    output tap_idx_t      newest_idx,
    output logic          sample_ready,
    input  wire logic     result_busy,
    input  wire logic     run_done
);

    localparam tap_idx_t last_idx = tap_idx_t'(max_taps - 1);

    engine_state_t state;
    tap_idx_t      clr_cnt;
    tap_idx_t      wr_ptr;
    logic          start_pend;
    logic          go;
    logic          in_fire;
    sample_t       ring [max_taps];

    // a start during the clear is kept until the ring is zeroed
    assign go        = start || start_pend;
    assign in_fire   = (state == st_wait_sample) && ss_tvalid && ss_tready;
    assign rd_sample = ring[rd_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state        <= st_clear;
            clr_cnt      <= '0;
            wr_ptr       <= '0;
            newest_idx   <= '0;
            start_pend   <= 1'b0;
            ss_tready    <= 1'b0;
            sample_ready <= 1'b0;
        end else begin
            ss_tready    <= (state == st_wait_sample) && ss_tvalid && !ss_tready;
            sample_ready <= in_fire;
            if (start) begin
                start_pend <= 1'b1;
            end
            case (state)
                st_clear: begin
                    if (clr_cnt == last_idx) begin
                        clr_cnt <= '0;
                        if (go) begin
                            state      <= st_wait_sample;
                            start_pend <= 1'b0;
                        end else begin
                            state <= st_idle;
                        end
                    end else begin
                        clr_cnt <= clr_cnt + 1'b1;
                    end
                end
                st_idle: begin
                    if (go) begin
                        state      <= st_wait_sample;
                        start_pend <= 1'b0;
                    end
                end
                st_wait_sample: begin
                    if (in_fire) begin
                        newest_idx <= wr_ptr;
                        wr_ptr     <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
                        state      <= st_compute;
                    end
                end
                st_compute: begin
                    if (result_busy) begin
                        state <= st_hold_result;
                    end
                end
                // next sample only once the held output has left
                st_hold_result: begin
                    if (!result_busy) begin
                        state <= run_done ? st_done : st_wait_sample;
                    end
                end
                st_done: begin
                    if (run_idle) begin
                        state   <= st_clear;
                        clr_cnt <= '0;
                        wr_ptr  <= '0;
                    end
                end
                default: begin
                    state <= st_clear;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state == st_clear) begin
            ring[clr_cnt] <= '0;
        end else if (in_fire) begin
            ring[wr_ptr] <= ss_tdata;
        end
    end

endmodule

`default_nettype wire

//--- src/fir_mac_engine.sv
`timescale 1ns/10ps
`default_nettype none

module fir_mac_engine
    import fir_data_pkg::*;
#(
    parameter int max_taps = 32
) (
    input  wire logic                   axis_clk,
    input  wire logic                   axis_rst_n,
    input  wire logic                   sample_ready,
    input  wire tap_idx_t               newest_idx,
    input  wire logic [$bits(tap_idx_t):0] tap_count,
    output tap_idx_t                    coef_idx,
    input  wire coef_t                  coef,
    output tap_idx_t                    rd_idx,
    input  wire sample_t                rd_sample,
    output logic                        result_valid,
    output acc_t                        result
);

    localparam tap_idx_t idx_mask = tap_idx_t'(max_taps - 1);

    logic     busy;
    tap_idx_t k;
    logic     last_k;
    logic     prod_v;
    logic     prod_first;
    logic     prod_last;
    acc_t     prod;
    acc_t     acc;

    // a tap count of zero behaves as a single tap
    assign last_k   = ({1'b0, k} + 1'b1) >= tap_count;
    assign coef_idx = k;
    // x[n-k] wraps inside the ring
    assign rd_idx   = (newest_idx - k) & idx_mask;
    assign result   = acc;

    ////////////////////////////////////////
    // tap sequencing

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            busy <= 1'b0;
            k    <= '0;
        end else if (sample_ready) begin
            busy <= 1'b1;
            k    <= '0;
        end else if (busy) begin
            if (last_k) begin
                busy <= 1'b0;
            end
            k <= k + 1'b1;
        end
    end

    ////////////////////////////////////////
    // multiply then accumulate

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_v       <= 1'b0;
            prod_first   <= 1'b0;
            prod_last    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_v       <= busy;
            prod_first   <= busy && (k == '0);
            prod_last    <= busy && last_k;
            result_valid <= prod_v && prod_last;
        end
    end

    always_ff @(posedge axis_clk) begin
        prod <= coef * rd_sample;
        if (prod_v) begin
            acc <= prod_first ? prod : acc + prod;
        end
    end

endmodule

`default_nettype wire

//--- src/fir_stream_out.sv
`timescale 1ns/10ps
`default_nettype none

module fir_stream_out
    import fir_reg_pkg::*;
    import fir_data_pkg::*;
(
    input  wire logic      axis_clk,
    input  wire logic      axis_rst_n,
    input  wire logic      result_valid,
    input  wire acc_t      result,
    input  wire reg_data_t data_length,
    input  wire logic      start,
    input  wire logic      sm_tready,
    output logic           sm_tvalid,
    output logic           sm_tlast,
    output acc_t           sm_tdata,
    output logic           result_busy,
    output logic           run_done
);

    reg_data_t out_cnt;
    logic      out_fire;

    assign out_fire    = sm_tvalid && sm_tready;
    assign result_busy = sm_tvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            out_cnt   <= '0;
            run_done  <= 1'b0;
        end else begin
            run_done <= out_fire && sm_tlast;
            if (start) begin
                out_cnt <= '0;
            end else if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
            end
            // tlast on the data_length-th output
            if (result_valid) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= (out_cnt + 32'd1) == data_length;
            end else if (out_fire) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (result_valid) begin
            sm_tdata <= result;
        end
    end

endmodule

`default_nettype wire

//--- src/fir_top.sv
`timescale 1ns/10ps
`default_nettype none

module fir_top
    import fir_reg_pkg::*;
    import fir_data_pkg::*;
#(
    parameter int max_taps = 32
) (
    input  wire logic      axis_clk,
    input  wire logic      axis_rst_n,
    input  wire logic      awvalid,
    input  wire reg_addr_t awaddr,
    input  wire logic      wvalid,
    input  wire reg_data_t wdata,
    output wire logic      awready,
    output wire logic      wready,
    input  wire logic      arvalid,
    input  wire reg_addr_t araddr,
    output wire logic      arready,
    output wire logic      rvalid,
    input  wire logic      rready,
    output wire reg_data_t rdata,
    input  wire logic      ss_tvalid,
    input  wire sample_t   ss_tdata,
    input  wire logic      ss_tlast,
    output wire logic      ss_tready,
    input  wire logic      sm_tready,
    output wire logic      sm_tvalid,
    output wire acc_t      sm_tdata,
    output wire logic      sm_tlast
);

    logic                     start;
    logic [$bits(tap_idx_t):0] tap_count;
    reg_data_t                data_length;
    logic                     run_done;
    logic                     run_idle;
    tap_idx_t                 coef_idx;
    coef_t                    coef;
    tap_idx_t                 rd_idx;
    sample_t                  rd_sample;
    tap_idx_t                 newest_idx;
    logic                     sample_ready;
    logic                     result_valid;
    acc_t                     result;
    logic                     result_busy;

    ////////////////////////////////////////
    // register port and configuration

    fir_ctrl_regs #(
        .max_taps (max_taps)
    ) i_ctrl_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .awready     (awready),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .rready      (rready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .coef_idx    (coef_idx),
        .coef        (coef),
        .start       (start),
        .tap_count   (tap_count),
        .data_length (data_length),
        .run_done    (run_done),
        .run_idle    (run_idle)
    );

    ////////////////////////////////////////
    // sample path

    // ss_tlast is ignored since data_length sets the run length
    fir_sample_buffer #(
        .max_taps (max_taps)
    ) i_sample_buffer (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .start        (start),
        .run_idle     (run_idle),
        .ss_tvalid    (ss_tvalid),
        .ss_tdata     (ss_tdata),
        .ss_tready    (ss_tready),
        .rd_idx       (rd_idx),
        .rd_sample    (rd_sample),
        .newest_idx   (newest_idx),
        .sample_ready (sample_ready),
        .result_busy  (result_busy),
        .run_done     (run_done)
    );

    fir_mac_engine #(
        .max_taps (max_taps)
    ) i_mac_engine (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .sample_ready (sample_ready),
        .newest_idx   (newest_idx),
        .tap_count    (tap_count),
        .coef_idx     (coef_idx),
        .coef         (coef),
        .rd_idx       (rd_idx),
        .rd_sample    (rd_sample),
        .result_valid (result_valid),
        .result       (result)
    );

    fir_stream_out i_stream_out (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result_valid (result_valid),
        .result       (result),
        .data_length  (data_length),
        .start        (start),
        .sm_tready    (sm_tready),
        .sm_tvalid    (sm_tvalid),
        .sm_tlast     (sm_tlast),
        .sm_tdata     (sm_tdata),
        .result_busy  (result_busy),
        .run_done     (run_done)
    );

endmodule

`default_nettype wire

//--- test/fir_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module fir_clk_gen #(
    parameter int half_period = 10,
    parameter int rst_cycles  = 5
) (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #(half_period) axis_clk = ~axis_clk;
    end

    // release away from the rising edge
    initial begin
        axis_rst_n = 1'b0;
        repeat (rst_cycles) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/fir_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module fir_assertions (
    input wire logic        axis_clk,
    input wire logic        axis_rst_n,
    input wire logic        awvalid,
    input wire logic        wvalid,
    input wire logic        awready,
    input wire logic        wready,
    input wire logic        arready,
    input wire logic        rvalid,
    input wire logic        rready,
    input wire logic        ss_tvalid,
    input wire logic        ss_tready,
    input wire logic        sm_tvalid,
    input wire logic        sm_tready,
    input wire logic [31:0] sm_tdata,
    input wire logic        sm_tlast
);

    int unsigned fail_cnt = 0;

    ////////////////////////////////////////
    // output stream

    // held output stays put until taken
    a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        $error("output stream changed while waiting for sm_tready");
        fail_cnt++;
    end

    a_tlast_valid: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tlast |-> sm_tvalid)
    else begin
        $error("sm_tlast high without sm_tvalid");
        fail_cnt++;
    end

    ////////////////////////////////////////
    // register port

    a_wr_ready_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready == wready)
    else begin
        $error("awready and wready differ");
        fail_cnt++;
    end

    a_wr_ready_cause: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready |-> $past(awvalid && wvalid))
    else begin
        $error("awready without a write request");
        fail_cnt++;
    end

    a_arready_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        arready |=> !arready)
    else begin
        $error("arready longer than one cycle");
        fail_cnt++;
    end

    a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_cnt++;
    end

    ////////////////////////////////////////
    // input stream

    a_ss_ready_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |=> !ss_tready)
    else begin
        $error("ss_tready longer than one cycle");
        fail_cnt++;
    end

    a_ss_ready_cause: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |-> $past(ss_tvalid))
    else begin
        $error("ss_tready without ss_tvalid");
        fail_cnt++;
    end

endmodule

bind fir_top fir_assertions i_assertions (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .awready    (awready),
    .wready     (wready),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .ss_tvalid  (ss_tvalid),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast)
);

`default_nettype wire

//--- test/fir_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fir_tb
    import fir_reg_pkg::*;
    import fir_data_pkg::*;
();

    localparam int max_taps     = 32;
    localparam int wait_limit   = 200;
    localparam int sample_limit = 2000;
    localparam int poll_limit   = 50;

    logic      axis_clk;
    logic      axis_rst_n;
    logic      awvalid;
    reg_addr_t awaddr;
    logic      wvalid;
    reg_data_t wdata;
    logic      awready;
    logic      wready;
    logic      arvalid;
    reg_addr_t araddr;
    logic      arready;
    logic      rvalid;
    logic      rready;
    reg_data_t rdata;
    logic      ss_tvalid;
    sample_t   ss_tdata;
    logic      ss_tlast;
    logic      ss_tready;
    logic      sm_tready;
    logic      sm_tvalid;
    acc_t      sm_tdata;
    logic      sm_tlast;

    // model state shared with the output side
    logic [31:0] coef_model [max_taps];
    logic [31:0] exp_vals [$];
    int          out_count = 0;
    int          run_len = 0;
    logic        backpressure = 1'b0;
    int          value_errors = 0;
    int          timeout_errors = 0;

    fir_clk_gen i_clk_gen (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    fir_top #(
        .max_taps (max_taps)
    ) i_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    ////////////////////////////////////////
    // reporting

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        int protocol_errors;
        protocol_errors = i_dut.i_assertions.fail_cnt;
        $display("error counts: %0d value, %0d timeout, %0d protocol",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors + timeout_errors + protocol_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("timeout at %0t ns: %s did not happen in time", $time, what);
        finish_run();
    endtask

    ////////////////////////////////////////
    // bus tasks start and end on a falling edge

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        int cycles;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        cycles  = 0;
        do begin
            @(negedge axis_clk);
            cycles++;
        end while (!awready && cycles < wait_limit);
        if (!awready) begin
            report_timeout("register write handshake");
        end else begin
            @(negedge axis_clk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        int cycles;
        int delay;
        data    = '0;
        arvalid = 1'b1;
        araddr  = addr;
        cycles  = 0;
        do begin
            @(negedge axis_clk);
            cycles++;
        end while (!arready && cycles < wait_limit);
        if (!arready) begin
            report_timeout("register read address handshake");
        end else begin
            @(negedge axis_clk);
            arvalid = 1'b0;
            cycles  = 0;
            while (!rvalid && cycles < wait_limit) begin
                @(negedge axis_clk);
                cycles++;
            end
            if (!rvalid) begin
                report_timeout("register read data");
            end else begin
                // late rready keeps rvalid and rdata waiting
                delay = $urandom_range(0, 2);
                repeat (delay) @(negedge axis_clk);
                data   = rdata;
                rready = 1'b1;
                @(negedge axis_clk);
                rready = 1'b0;
            end
        end
    endtask

    task automatic send_sample(input sample_t data, input logic last);
        int cycles;
        ss_tvalid = 1'b1;
        ss_tdata  = data;
        ss_tlast  = last;
        cycles    = 0;
        do begin
            @(negedge axis_clk);
            cycles++;
        end while (!ss_tready && cycles < sample_limit);
        if (!ss_tready) begin
            report_timeout("input sample acceptance");
        end else begin
            @(negedge axis_clk);
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // one filter run from configuration to the done read

    task automatic run_fir(input int taps, input int len, input logic use_bp);
        logic [31:0] x [$];
        logic [31:0] acc;
        reg_data_t   rd;
        int          cycles;
        int          k;
        reg_write(addr_data_length, reg_data_t'(len));
        reg_write(addr_tap_count, reg_data_t'(taps));
        for (int i = 0; i < max_taps; i++) begin
            coef_model[i] = $urandom;
            reg_write(reg_addr_t'(addr_coef_base + 4 * i), coef_model[i]);
        end
        reg_read(addr_data_length, rd);
        check_value("data length readback", rd, reg_data_t'(len));
        reg_read(addr_tap_count, rd);
        check_value("tap count readback", rd, reg_data_t'(taps));
        for (int i = 0; i < 4; i++) begin
            k = $urandom_range(0, max_taps - 1);
            reg_read(reg_addr_t'(addr_coef_base + 4 * k), rd);
            check_value($sformatf("coef %0d readback", k), rd, coef_model[k]);
        end
        reg_read(addr_ap_ctrl, rd);
        check_value("ap_ctrl before start", rd, reg_data_t'(1) << ap_idle_bit);

        // reference outputs with zero history before the run
        exp_vals.delete();
        for (int n = 0; n < len; n++) begin
            x.push_back($urandom);
            acc = '0;
            for (int j = 0; j < taps; j++) begin
                if (n >= j) begin
                    acc = acc + coef_model[j] * x[n - j];
                end
            end
            exp_vals.push_back(acc);
        end
        out_count    = 0;
        run_len      = len;
        backpressure = use_bp;

        reg_write(addr_ap_ctrl, reg_data_t'(1) << ap_start_bit);
        for (int n = 0; n < len; n++) begin
            send_sample(x[n], n == len - 1);
        end
        cycles = 0;
        while (out_count < len && cycles < sample_limit) begin
            @(negedge axis_clk);
            cycles++;
        end
        if (out_count < len) begin
            report_timeout("the last output of the run");
        end

        // poll for done and expect idle on the next read
        rd     = '0;
        cycles = 0;
        while (!rd[ap_done_bit] && cycles < poll_limit) begin
            reg_read(addr_ap_ctrl, rd);
            cycles++;
        end
        if (!rd[ap_done_bit]) begin
            report_timeout("ap_done after the last output");
        end
        check_value("ap_ctrl done read", rd, reg_data_t'(1) << ap_done_bit);
        reg_read(addr_ap_ctrl, rd);
        check_value("ap_ctrl after done read", rd, reg_data_t'(1) << ap_idle_bit);
        backpressure = 1'b0;
    endtask

    ////////////////////////////////////////
    // output ready and result checks on the falling edge

    always @(negedge axis_clk) begin : output_side
        logic ready_now;
        ready_now = backpressure ? ($urandom_range(0, 3) != 0) : 1'b1;
        sm_tready = ready_now;
        if (sm_tvalid && ready_now) begin
            if (out_count < exp_vals.size()) begin
                check_value($sformatf("output %0d", out_count), sm_tdata, exp_vals[out_count]);
                check_value($sformatf("sm_tlast on output %0d", out_count),
                            32'(sm_tlast), 32'(out_count == run_len - 1));
            end else begin
                value_errors++;
                $display("[FAIL] %0t ns unexpected output %h beyond the run length",
                         $time, sm_tdata);
            end
            out_count++;
        end
    end

    initial begin : stimulus
        int cycles;
        void'($urandom(52));
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;

        cycles = 0;
        while (axis_rst_n !== 1'b1 && cycles < wait_limit) begin
            @(negedge axis_clk);
            cycles++;
        end
        if (axis_rst_n !== 1'b1) begin
            report_timeout("reset release");
        end

        // outputs quiet after reset
        check_value("awready after reset", 32'(awready), 32'd0);
        check_value("wready after reset", 32'(wready), 32'd0);
        check_value("arready after reset", 32'(arready), 32'd0);
        check_value("rvalid after reset", 32'(rvalid), 32'd0);
        check_value("ss_tready after reset", 32'(ss_tready), 32'd0);
        check_value("sm_tvalid after reset", 32'(sm_tvalid), 32'd0);
        check_value("sm_tlast after reset", 32'(sm_tlast), 32'd0);

        // no sample taken before ap_start even during the clear
        ss_tvalid = 1'b1;
        ss_tdata  = $urandom;
        repeat (max_taps + 8) begin
            @(negedge axis_clk);
            check_value("ss_tready before start", 32'(ss_tready), 32'd0);
        end
        ss_tvalid = 1'b0;

        run_fir(32, 40, 1'b0);
        // second run starts from a cleared ring
        run_fir(11, 24, 1'b1);
        repeat (4) @(negedge axis_clk);
        finish_run();
    end

endmodule

`default_nettype wire

//--- vlog.f
src/fir_reg_pkg.sv
src/fir_data_pkg.sv
src/fir_ctrl_regs.sv
src/fir_sample_buffer.sv
src/fir_mac_engine.sv
src/fir_stream_out.sv
src/fir_top.sv
test/fir_clk_gen.sv
test/fir_assertions.sv
test/fir_tb.sv

//--- Bender.yml
package:
  name: fir_filter

sources:
  - src/fir_reg_pkg.sv
  - src/fir_data_pkg.sv
  - src/fir_ctrl_regs.sv
  - src/fir_sample_buffer.sv
  - src/fir_mac_engine.sv
  - src/fir_stream_out.sv
  - src/fir_top.sv
  - target: test
    files:
      - test/fir_clk_gen.sv
      - test/fir_assertions.sv
      - test/fir_tb.sv
